// File: audio_mixer.sv
// Stereo mixer stage crossfeeding left and right by mode for signed or unsigned samples
`timescale 1ns/1ps

module audio_mixer
	import audio_pkg::*;
(
	input  logic      clk_sys,
	input  logic      resetd,
	input  logic      in_valid,
	output logic      in_ready,
	input  sample_t   in_left,
	input  sample_t   in_right,
	input  logic      in_signed,
	input  mix_mode_t audio_mix,
	output logic      out_valid,
	input  logic      out_ready,
	output stereo_t   out_data
);

	logic    run;
	logic    in_fire;
	sample_t mix_left;
	sample_t mix_right;

	// Arithmetic or logical divide by a power of two
	function automatic sample_t shr(input sample_t x, input int unsigned n, input logic sgn);
		logic signed [$bits(sample_t)-1:0] sx;
		sx = x;
		if (sgn) begin
			return sx >>> n;
		end
		return x >> n;
	endfunction

	// One output channel, wraps at sample width
	function automatic sample_t mix_chan(input sample_t own, input sample_t other,
			input mix_mode_t mode, input logic sgn);
		sample_t mixed;
		case (mode)
			MIX_DIRECT: mixed = own;
			MIX_LIGHT:  mixed = own - shr(own, 3, sgn) + shr(other, 3, sgn);
			MIX_MEDIUM: mixed = own - shr(own, 2, sgn) + shr(other, 2, sgn);
			MIX_MONO:   mixed = shr(own, 1, sgn) + shr(other, 1, sgn);
		endcase
		return mixed;
	endfunction

	assign mix_left  = mix_chan(in_left, in_right, audio_mix, in_signed);
	assign mix_right = mix_chan(in_right, in_left, audio_mix, in_signed);

	// Held low through reset, then open
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	assign in_ready = run & (~out_valid | out_ready);
	assign in_fire  = in_valid & in_ready;

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			out_valid <= 1'b0;
		end else if (in_fire) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (in_fire) begin
			out_data.left      <= mix_left;
			out_data.right     <= mix_right;
			out_data.is_signed <= in_signed;
		end
	end

	assert property (@(posedge clk_sys) disable iff (resetd)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("mixer output changed while stalled");

endmodule

// File: audio_pkg.sv
// Sample, stereo pair and mix mode types for the audio path
`include "hps_defines.svh"

package audio_pkg;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	// Crossfeed mode of the mixer
	typedef logic [1:0] mix_mode_t;

	localparam mix_mode_t MIX_DIRECT = 2'd0;
	localparam mix_mode_t MIX_LIGHT  = 2'd1;  // 1/8 of the other channel
	localparam mix_mode_t MIX_MEDIUM = 2'd2;  // 1/4 of the other channel
	localparam mix_mode_t MIX_MONO   = 2'd3;

	// Signedness rides along with each pair
	typedef struct packed {
		sample_t left;
		sample_t right;
		logic    is_signed;
	} stereo_t;

endpackage

// File: filelist.f
+incdir+.
host_io_pkg.sv
audio_pkg.sv
host_cmd_decoder.sv
audio_mixer.sv
sample_fifo.sv
volume_stage.sv
menu_audio_top.sv
tb_menu_audio.sv

// File: host_cmd_decoder.sv
// Host I/O command decoder holding the LED and volume registers and composing board LEDs
`timescale 1ns/1ps
`include "hps_defines.svh"

module host_cmd_decoder
	import host_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       io_uio,
	input  logic       io_clk,
	input  hps_word_t  io_din,
	output logic       io_ack,
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	input  logic       led_user,
	output logic [7:0] led,
	output vol_att_t   vol_att
);

	logic       strobe_q;
	hps_word_t  din_q;
	logic       has_cmd;
	hps_cmd_t   cmd;
	led_ctrl_t  led_ctrl;
	logic       led_p;
	logic       led_d;
	logic [7:0] led_core;

	// ========================================
	// Strobe edge and acknowledge
	// ========================================

	// io_ack doubles as the previous io_clk sample
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_ack   <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			io_ack   <= io_clk;
			strobe_q <= io_clk & ~io_ack;
		end
	end

	// Word taken together with its edge
	always_ff @(posedge clk_sys) begin
		din_q <= io_din;
	end

	// ========================================
	// Command and data sequencing
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			led_ctrl <= '0;
			vol_att  <= '0;
		end else if (!io_uio) begin
			has_cmd <= 1'b0;
		end else if (strobe_q) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
			end else if (cmd == `HPS_CMD_LED) begin
				led_ctrl <= led_ctrl_t'(din_q);
			end else if (cmd == `HPS_CMD_VOL) begin
				vol_att <= vol_att_t'(din_q[4:0]);
			end
		end
	end

	// First word of a transfer
	always_ff @(posedge clk_sys) begin
		if (io_uio && strobe_q && !has_cmd) begin
			cmd <= din_q[7:0];
		end
	end

	// ========================================
	// LED composition
	// ========================================

	assign led_p = led_power[1] ? ~led_power[0] : 1'b0;
	assign led_d = led_disk[1] ? ~led_disk[0] : led_disk[0];

	// Power on bit 4, disk on bit 2, user on bit 0
	assign led_core = {3'b000, led_p, 1'b0, led_d, 1'b0, led_user};

	always_ff @(posedge clk_sys) begin
		led <= (led_ctrl.overtake & led_ctrl.state) | (~led_ctrl.overtake & led_core);
	end

	// Registers only move on a data word inside a transfer
	assert property (@(posedge clk_sys) disable iff (resetd)
		!(io_uio && strobe_q && has_cmd) |=> $stable(led_ctrl) && $stable(vol_att))
		else $error("LED or volume register written outside a data word");

endmodule

// File: host_io_pkg.sv
// Host bus word, command code and LED and volume control types
`include "hps_defines.svh"

package host_io_pkg;

	// Raw word from the host strobe bus
	typedef logic [`HPS_DATA_W-1:0] hps_word_t;

	// Low byte of the first word of a transfer
	typedef logic [7:0] hps_cmd_t;

	// Overtake in the upper byte, matches the word layout of command 0x25
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ctrl_t;

	// Attenuation from command 0x26
	typedef struct packed {
		logic       mute;
		logic [3:0] shift;
	} vol_att_t;

endpackage

// File: hps_defines.svh
// Shared widths, host command codes and sample buffer depth for the menu audio design
`ifndef HPS_DEFINES_SVH
`define HPS_DEFINES_SVH

// ========================================
// Host bus
// ========================================

// One host data word
`define HPS_DATA_W 16

// Command codes, sent as the first word of a transfer
`define HPS_CMD_LED 8'h25
`define HPS_CMD_VOL 8'h26

// ========================================
// Audio path
// ========================================

// Bits per audio sample
`define SAMPLE_W 16

// Stereo pairs held between mixer and volume stage
`define SAMPLE_FIFO_DEPTH 4

`endif

// File: menu_audio_top.sv
// Top level joining the host command decoder with the mixer, sample FIFO and volume stage
`timescale 1ns/1ps
`include "hps_defines.svh"

module menu_audio_top
	import host_io_pkg::*;
	import audio_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,
	// Host bus
	input  logic       io_uio,
	input  logic       io_clk,
	input  hps_word_t  io_din,
	output logic       io_ack,
	// Core LED requests and board LEDs
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	input  logic       led_user,
	output logic [7:0] led,
	// Input sample stream
	input  logic       in_valid,
	output logic       in_ready,
	input  sample_t    in_left,
	input  sample_t    in_right,
	input  logic       in_signed,
	input  mix_mode_t  audio_mix,
	// Output sample stream
	output logic       out_valid,
	input  logic       out_ready,
	output sample_t    out_left,
	output sample_t    out_right
);

	vol_att_t vol_att;
	logic     mix_valid;
	logic     mix_ready;
	stereo_t  mix_data;
	logic     buf_valid;
	logic     buf_ready;
	stereo_t  buf_data;

	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.io_uio    (io_uio),
		.io_clk    (io_clk),
		.io_din    (io_din),
		.io_ack    (io_ack),
		.led_power (led_power),
		.led_disk  (led_disk),
		.led_user  (led_user),
		.led       (led),
		.vol_att   (vol_att)
	);

	// ========================================
	// Audio path
	// ========================================

	audio_mixer u_audio_mixer (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_left   (in_left),
		.in_right  (in_right),
		.in_signed (in_signed),
		.audio_mix (audio_mix),
		.out_valid (mix_valid),
		.out_ready (mix_ready),
		.out_data  (mix_data)
	);

	sample_fifo #(
		.DEPTH (`SAMPLE_FIFO_DEPTH)
	) u_sample_fifo (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.wr_valid (mix_valid),
		.wr_ready (mix_ready),
		.wr_data  (mix_data),
		.rd_valid (buf_valid),
		.rd_ready (buf_ready),
		.rd_data  (buf_data)
	);

	volume_stage u_volume_stage (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.in_valid  (buf_valid),
		.in_ready  (buf_ready),
		.in_data   (buf_data),
		.vol_att   (vol_att),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_left  (out_left),
		.out_right (out_right)
	);

endmodule

// File: menu_audio_vectors.txt
# name op a b c d exp0 exp1, fields after op in hex
# ledin a=led_power b=led_disk c=led_user exp0=led; xfer/loose a=command b,c=data d=data count exp0=led
# samp a=left b=right c=mode d=signed exp0,exp1=output pair; burst a=random sample count
led_reset ledin 0 0 0 0 00 0
led_combo_a ledin 2 1 1 0 15 0
led_combo_b ledin 3 3 0 0 00 0
led_combo_c ledin 1 2 1 0 05 0
led_overtake xfer 0025 f05a 0 1 55 0
led_overtake_bit0 xfer 0025 0100 0 1 04 0
led_uio_low loose 0025 ffff 0 1 04 0
led_unknown_cmd xfer 0033 ffff ffff 2 04 0
led_multi_word xfer 0025 ff00 0000 2 05 0
led_combo_d ledin 2 0 0 0 10 0
mix0_unsigned samp 1234 5678 0 0 1234 5678
mix1_unsigned samp 8000 0010 1 0 7002 100e
mix1_signed samp 8000 0010 1 1 9002 f00e
mix2_unsigned samp 4000 c000 2 0 6000 a000
mix2_signed samp 4000 c000 2 1 2000 e000
mix3_unsigned samp ffff 0001 3 0 7fff 7fff
mix3_signed samp fff0 0020 3 1 0008 0008
vol_shift4 xfer 0026 0004 0 1 10 0
shift4_unsigned samp 8000 1234 0 0 0800 0123
shift4_signed samp 8000 1234 0 1 f800 0123
vol_shift15 xfer 0026 000f 0 1 10 0
shift15_signed samp 8000 7fff 0 1 ffff 0000
shift15_unsigned samp 8000 7fff 0 0 0001 0000
vol_mute xfer 0026 0010 0 1 10 0
mute_signed samp 1234 abcd 2 1 0000 0000
vol_shift1 xfer 0026 0001 0 1 10 0
burst_shift1 burst 14 0 0 0 0 0
vol_multi_word xfer 0026 0010 0000 2 10 0
burst_shift0 burst 14 0 0 0 0 0

// File: run_sim.sh
#!/bin/sh
# Build and run the menu audio testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_menu_audio \
	-f filelist.f -o sim_menu_audio > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/sim_menu_audio > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sample_fifo.sv
// Circular valid/ready buffer of stereo pairs between mixer and volume stage
`timescale 1ns/1ps
`include "hps_defines.svh"

module sample_fifo
	import audio_pkg::*;
#(
	parameter int DEPTH = `SAMPLE_FIFO_DEPTH
)
(
	input  logic    clk_sys,
	input  logic    resetd,
	input  logic    wr_valid,
	output logic    wr_ready,
	input  stereo_t wr_data,
	output logic    rd_valid,
	input  logic    rd_ready,
	output stereo_t rd_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	stereo_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             wr_fire;
	logic             rd_fire;

	assign full     = (count == FULL_CNT);
	assign wr_ready = ~full;
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];
	assign wr_fire  = wr_valid & wr_ready;
	assign rd_fire  = rd_valid & rd_ready;

	always_ff @(posedge clk_sys) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ========================================
	// Pointers and occupancy
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_fire, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Full with no read means nothing gets written
	assert property (@(posedge clk_sys) disable iff (resetd)
		full && !rd_fire |=> full && $stable(wr_ptr))
		else $error("write accepted into a full sample FIFO");

endmodule

// File: tb_menu_audio.sv
// Self-checking testbench for the menu audio top level, driven from a vectors file
`timescale 1ns/1ps
`include "hps_defines.svh"

module tb_menu_audio
	import host_io_pkg::*;
	import audio_pkg::*;
();

	localparam int CLK_NS         = 40;
	localparam int RESET_CYCLES   = 16;
	localparam int CYCLES_PER_VEC = 200;

	logic       clk_sys;
	logic       resetd;
	logic       io_uio;
	logic       io_clk;
	hps_word_t  io_din;
	logic       io_ack;
	logic [1:0] led_power;
	logic [1:0] led_disk;
	logic       led_user;
	logic [7:0] led;
	logic       in_valid;
	logic       in_ready;
	sample_t    in_left;
	sample_t    in_right;
	logic       in_signed;
	mix_mode_t  audio_mix;
	logic       out_valid;
	logic       out_ready;
	sample_t    out_left;
	sample_t    out_right;

	// Vectors as read, fields packed a,b,c,d,exp0,exp1
	string       vec_name[$];
	string       vec_op[$];
	logic [95:0] vec_field[$];
	logic        loaded;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic [31:0] rng;
	vol_att_t    vol_model;

	// Pending stream samples {left, right, mode, signed} and expected output pairs
	logic [34:0] stim_q[$];
	logic [31:0] expect_q[$];

	menu_audio_top u_menu_audio_top (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.io_uio    (io_uio),
		.io_clk    (io_clk),
		.io_din    (io_din),
		.io_ack    (io_ack),
		.led_power (led_power),
		.led_disk  (led_disk),
		.led_user  (led_user),
		.led       (led),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_left   (in_left),
		.in_right  (in_right),
		.in_signed (in_signed),
		.audio_mix (audio_mix),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_left  (out_left),
		.out_right (out_right)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_NS / 2) clk_sys = ~clk_sys;
		end
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Divide by 2**n, sign extended first for signed samples
	function automatic sample_t div_pow2(input sample_t x, input int n, input logic sgn);
		logic [31:0] wide;
		wide = sgn ? {{16{x[15]}}, x} : {16'h0000, x};
		wide = wide >> n;
		return wide[15:0];
	endfunction

	function automatic sample_t expect_mix(input sample_t own, input sample_t other,
			input mix_mode_t mode, input logic sgn);
		sample_t r;
		case (mode)
			2'd0:    r = own;
			2'd1:    r = own - div_pow2(own, 3, sgn) + div_pow2(other, 3, sgn);
			2'd2:    r = own - div_pow2(own, 2, sgn) + div_pow2(other, 2, sgn);
			default: r = div_pow2(own, 1, sgn) + div_pow2(other, 1, sgn);
		endcase
		return r;
	endfunction

	function automatic sample_t expect_vol(input sample_t x, input vol_att_t att,
			input logic sgn);
		if (att.mute) begin
			return '0;
		end
		return div_pow2(x, int'(att.shift), sgn);
	endfunction

	// ========================================
	// Host bus and LED tasks
	// ========================================

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_led(input string name, input logic [7:0] exp);
		assert (led === exp) else begin
			$display("MISMATCH %s: led expected %h, actual %h", name, exp, led);
			errors++;
		end
	endtask

	// One strobe, with the acknowledge checked on both edges
	task automatic host_word(input string name, input hps_word_t w);
		step();
		io_din = w;
		step();
		io_clk = 1'b1;
		step();
		assert (io_ack === 1'b1) else begin
			$display("MISMATCH %s: io_ack expected 1, actual %b", name, io_ack);
			errors++;
		end
		io_clk = 1'b0;
		step();
		assert (io_ack === 1'b0) else begin
			$display("MISMATCH %s: io_ack expected 0, actual %b", name, io_ack);
			errors++;
		end
	endtask

	task automatic host_xfer(input string name, input logic uio, input logic [95:0] f);
		hps_word_t words[3];
		int        nwords;
		words[0] = f[95:80];
		words[1] = f[79:64];
		words[2] = f[63:48];
		nwords   = int'(f[47:32]);
		if (nwords > 2) begin
			nwords = 2;
		end
		step();
		io_uio = uio;
		for (int i = 0; i <= nwords; i++) begin
			host_word(name, words[i]);
		end
		// Last volume word wins
		if (uio && words[0][7:0] == `HPS_CMD_VOL && nwords > 0) begin
			vol_model = vol_att_t'(words[nwords][4:0]);
		end
		step();
		io_uio = 1'b0;
		repeat (4) step();
		check_led(name, f[23:16]);
	endtask

	task automatic apply_led_inputs(input string name, input logic [95:0] f);
		step();
		led_power = f[81:80];
		led_disk  = f[65:64];
		led_user  = f[48];
		repeat (4) step();
		check_led(name, f[23:16]);
	endtask

	// ========================================
	// Sample stream tasks
	// ========================================

	task automatic queue_random_samples(input int n);
		sample_t   l;
		sample_t   r;
		mix_mode_t m;
		logic      s;
		for (int i = 0; i < n; i++) begin
			rng = xorshift(rng);
			l   = rng[15:0];
			r   = rng[31:16];
			rng = xorshift(rng);
			m   = rng[1:0];
			s   = rng[2];
			stim_q.push_back({l, r, m, s});
			expect_q.push_back({expect_vol(expect_mix(l, r, m, s), vol_model, s),
				expect_vol(expect_mix(r, l, m, s), vol_model, s)});
		end
	endtask

	// Handshake sampled at the falling edge, where nothing moves
	task automatic feed_inputs();
		logic [34:0] s;
		logic        fire;
		step();
		while (stim_q.size() > 0) begin
			s         = stim_q[0];
			in_valid  = 1'b1;
			in_left   = s[34:19];
			in_right  = s[18:3];
			audio_mix = s[2:1];
			in_signed = s[0];
			@(negedge clk_sys);
			fire = in_ready;
			step();
			if (fire) begin
				void'(stim_q.pop_front());
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic watch_outputs(input string name, input int total, input logic random_ready);
		int          got;
		logic        held;
		sample_t     last_left;
		sample_t     last_right;
		logic [31:0] exp;
		got        = 0;
		held       = 1'b0;
		last_left  = '0;
		last_right = '0;
		while (got < total) begin
			step();
			if (random_ready) begin
				rng       = xorshift(rng);
				out_ready = rng[7];
			end else begin
				out_ready = 1'b1;
			end
			@(negedge clk_sys);
			if (held) begin
				assert (out_valid === 1'b1 && out_left === last_left
						&& out_right === last_right) else begin
					$display("Output pair changed while stalled in %s", name);
					errors++;
				end
			end
			if (out_valid === 1'b1 && out_ready) begin
				if (expect_q.size() == 0) begin
					$display("Output pair in %s with no sample pending", name);
					errors++;
				end else begin
					exp = expect_q.pop_front();
					assert ({out_left, out_right} === exp) else begin
						$display("MISMATCH %s: pair expected %h %h, actual %h %h", name,
							exp[31:16], exp[15:0], out_left, out_right);
						errors++;
					end
				end
				got++;
			end
			held       = (out_valid === 1'b1) && !out_ready;
			last_left  = out_left;
			last_right = out_right;
		end
		step();
		out_ready = 1'b1;
	endtask

	task automatic run_stream(input string name, input logic random_ready);
		int total;
		total = stim_q.size();
		fork
			feed_inputs();
			watch_outputs(name, total, random_ready);
		join
	endtask

	// ========================================
	// Vector handling
	// ========================================

	task automatic load_vectors(output logic ok);
		int          fd;
		int          n;
		string       line;
		string       name;
		string       op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		logic [15:0] e0;
		logic [15:0] e1;
		fd = $fopen("menu_audio_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, a, b, c, d, e0, e1);
					if (n == 8) begin
						vec_name.push_back(name);
						vec_op.push_back(op);
						vec_field.push_back({a, b, c, d, e0, e1});
					end else if (n > 0) begin
						$display("Malformed line in vectors file: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_vector(input int i);
		string       name;
		string       op;
		logic [95:0] f;
		int          errs_before;
		name        = vec_name[i];
		op          = vec_op[i];
		f           = vec_field[i];
		errs_before = errors;
		if (op == "ledin") begin
			apply_led_inputs(name, f);
		end else if (op == "xfer") begin
			host_xfer(name, 1'b1, f);
		end else if (op == "loose") begin
			host_xfer(name, 1'b0, f);
		end else if (op == "samp") begin
			stim_q.push_back({f[95:80], f[79:64], f[49:48], f[32]});
			expect_q.push_back(f[31:0]);
			run_stream(name, 1'b0);
		end else if (op == "burst") begin
			queue_random_samples(int'(f[95:80]));
			run_stream(name, 1'b1);
		end else begin
			$display("Unknown operation %s in vector %s", op, name);
			errors++;
		end
		tests_run++;
		if (errors == errs_before) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s, %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin : main
		logic ok;
		resetd       = 1'b1;
		io_uio       = 1'b0;
		io_clk       = 1'b0;
		io_din       = '0;
		led_power    = 2'b00;
		led_disk     = 2'b00;
		led_user     = 1'b0;
		in_valid     = 1'b0;
		in_left      = '0;
		in_right     = '0;
		in_signed    = 1'b0;
		audio_mix    = '0;
		out_ready    = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rng          = 32'd99;
		vol_model    = '0;
		loaded       = 1'b0;
		load_vectors(ok);
		if (!ok) begin
			$display("Cannot open menu_audio_vectors.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (RESET_CYCLES) step();
			assert (in_ready === 1'b0 && out_valid === 1'b0 && io_ack === 1'b0) else begin
				$display("Stream or host handshake active during reset");
				errors++;
			end
			resetd = 1'b0;
			for (int i = 0; i < vec_name.size(); i++) begin
				run_vector(i);
			end
			$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
				tests_run, tests_run - tests_failed, tests_failed, errors);
			if (errors == 0 && tests_run > 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// Budget scales with the number of vectors
	initial begin : watchdog
		wait (loaded === 1'b1);
		repeat (vec_name.size() * CYCLES_PER_VEC + RESET_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before all vectors finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: volume_stage.sv
// Volume stage applying mute or shift attenuation and driving the output stream
`timescale 1ns/1ps

module volume_stage
	import audio_pkg::*;
	import host_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     resetd,
	input  logic     in_valid,
	output logic     in_ready,
	input  stereo_t  in_data,
	input  vol_att_t vol_att,
	output logic     out_valid,
	input  logic     out_ready,
	output sample_t  out_left,
	output sample_t  out_right
);

	logic in_fire;

	// Mute wins over the shift
	function automatic sample_t attenuate(input sample_t x, input vol_att_t att,
			input logic sgn);
		logic signed [$bits(sample_t)-1:0] sx;
		sx = x;
		if (att.mute) begin
			return '0;
		end
		if (sgn) begin
			return sx >>> att.shift;
		end
		return x >> att.shift;
	endfunction

	assign in_ready = ~out_valid | out_ready;
	assign in_fire  = in_valid & in_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			out_valid <= 1'b0;
		end else if (in_fire) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Attenuation taken at entry, result held until accepted
	always_ff @(posedge clk_sys) begin
		if (in_fire) begin
			out_left  <= attenuate(in_data.left, vol_att, in_data.is_signed);
			out_right <= attenuate(in_data.right, vol_att, in_data.is_signed);
		end
	end

endmodule
